// File: filelist.f
sa_pkg.sv
tile_controller.sv
tile_loader.sv
tile_compute.sv
tile_store.sv
sa_engine_top.sv
tb_axi_mem.sv
tb_sa_engine.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sa_engine
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_sa_engine.sv
// Jobs keep all buffers below 0x1000, the size of the memory model
module tb_sa_engine;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS         = 10;
  localparam int NUM_JOBS       = 6;
  localparam int MAX_JOB_CYCLES = 300;
  // Job budget plus margin for reset and tile filling
  localparam int WATCHDOG_NS    = NUM_JOBS * MAX_JOB_CYCLES * CLK_NS + 2000;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            start;
  sa_pkg::sa_cfg_t cfg;
  sa_pkg::axi_ar_t ar;
  sa_pkg::axi_r_t  r;
  sa_pkg::axi_aw_t aw;
  sa_pkg::axi_w_t  w;
  sa_pkg::axi_b_t  b;
  logic            arvalid;
  logic            arready;
  logic            rvalid;
  logic            rready;
  logic            awvalid;
  logic            awready;
  logic            wvalid;
  logic            wready;
  logic            bvalid;
  logic            bready;
  logic            busy;
  logic            done;
  logic            error;
  logic            bd_we;
  sa_pkg::addr_t   bd_addr;
  sa_pkg::word_t   bd_data;
  int              err_beat;
  int              rd_beats;

  string           test_name;
  int              seed = 32'hd71;
  sa_pkg::word_t   exp_c [16];
  logic            exp_error;
  logic            job_end;
  logic            illegal_job;
  logic [4:0]      ar_cnt;
  logic [2:0]      aw_cnt;
  logic [1:0]      w_row;
  logic [1:0]      w_beat;
  sa_pkg::addr_t   exp_ar_addr;
  logic [7:0]      exp_ar_len;
  logic [4:0]      exp_ar_cnt;
  sa_pkg::addr_t   exp_aw_addr;
  sa_pkg::word_t   exp_w;

  always #(CLK_NS / 2) clk = ~clk;

  sa_engine_top i_dut (
    .M_AXI_ACLK (clk),       .M_AXI_ARESETN (rst_n),   .i_start (start),
    .i_cfg      (cfg),       .i_arready     (arready), .i_r     (r),
    .i_rvalid   (rvalid),    .i_awready     (awready), .i_wready (wready),
    .i_b        (b),         .i_bvalid      (bvalid),  .o_ar    (ar),
    .o_arvalid  (arvalid),   .o_rready      (rready),  .o_aw    (aw),
    .o_awvalid  (awvalid),   .o_w           (w),       .o_wvalid (wvalid),
    .o_bready   (bready),    .o_busy        (busy),    .o_done  (done),
    .o_error    (error)
  );

  tb_axi_mem i_mem (
    .M_AXI_ACLK (clk),       .M_AXI_ARESETN (rst_n),   .i_ar    (ar),
    .i_arvalid  (arvalid),   .i_rready      (rready),  .i_aw    (aw),
    .i_awvalid  (awvalid),   .i_w           (w),       .i_wvalid (wvalid),
    .i_bready   (bready),    .i_bd_we       (bd_we),   .i_bd_addr (bd_addr),
    .i_bd_data  (bd_data),   .i_err_beat    (err_beat), .o_arready (arready),
    .o_r        (r),         .o_rvalid      (rvalid),  .o_awready (awready),
    .o_wready   (wready),    .o_b           (b),       .o_bvalid (bvalid),
    .o_rd_beats (rd_beats)
  );

  // ========================================
  // Expected bus traffic
  // ========================================
  always @(posedge clk) begin
    if (start && !busy) begin
      ar_cnt <= '0;
      aw_cnt <= '0;
      w_row  <= '0;
      w_beat <= '0;
    end else begin
      if (arvalid && arready) begin
        ar_cnt <= ar_cnt + 5'd1;
      end
      if (awvalid && awready) begin
        aw_cnt <= aw_cnt + 3'd1;
      end
      if (wvalid && wready) begin
        w_beat <= w_beat + 2'd1;
        if (w_beat == 2'd3) begin
          w_row <= w_row + 2'd1;
        end
      end
    end
  end

  // First four reads are the A rows, then one read per B row
  assign exp_ar_addr = (ar_cnt < 5'd4) ?
                       cfg.base_a + sa_pkg::addr_t'(ar_cnt) * cfg.stride_a :
                       cfg.base_b + sa_pkg::addr_t'(ar_cnt - 5'd4) * cfg.stride_b;
  assign exp_ar_len  = (ar_cnt < 5'd4) ? 8'(int'(cfg.k_len) / 4 - 1) : 8'd0;
  assign exp_ar_cnt  = 5'(4 + int'(cfg.k_len));
  assign exp_aw_addr = cfg.base_c + sa_pkg::addr_t'(aw_cnt) * cfg.stride_c;
  assign exp_w       = exp_c[{w_row, w_beat}];

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |->
    !(busy || done || error || arvalid || rready || awvalid || wvalid || bready))
    else stop_on_error("Outputs were not all low right after reset");

  a_ar_addr: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && arready |-> ar.addr == exp_ar_addr)
    else stop_on_error($sformatf("Error %s AR addr expected %h actual %h", test_name,
                                 $sampled(exp_ar_addr), $sampled(ar.addr)));

  a_ar_len: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && arready |-> ar.len == exp_ar_len)
    else stop_on_error($sformatf("Error %s AR len expected %0d actual %0d", test_name,
                                 $sampled(exp_ar_len), $sampled(ar.len)));

  a_aw: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && awready |-> aw.addr == exp_aw_addr && aw.len == 8'd3)
    else stop_on_error($sformatf("Error %s AW addr/len expected %h/3 actual %h/%0d",
                                 test_name, $sampled(exp_aw_addr), $sampled(aw.addr),
                                 $sampled(aw.len)));

  a_w_data: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && wready |-> w.data == exp_w)
    else stop_on_error($sformatf("Error %s C[%0d][%0d] expected %h actual %h", test_name,
                                 $sampled(w_row), $sampled(w_beat), $sampled(exp_w),
                                 $sampled(w.data)));

  a_w_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && wready |-> w.last == (w_beat == 2'd3) && w.strb == 4'hf)
    else stop_on_error($sformatf("Error %s W last/strb expected %0b/f actual %0b/%h",
                                 test_name, $sampled(w_beat == 2'd3), $sampled(w.last),
                                 $sampled(w.strb)));

  a_illegal_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    illegal_job |-> !arvalid && !awvalid)
    else stop_on_error("A bus request was issued for a job with an illegal K");

  a_job_bursts: assert property (@(posedge clk) disable iff (!rst_n)
    job_end && !illegal_job |-> ar_cnt == exp_ar_cnt && aw_cnt == 3'd4)
    else stop_on_error($sformatf("Error %s AR/AW bursts expected %0d/4 actual %0d/%0d",
                                 test_name, $sampled(exp_ar_cnt), $sampled(ar_cnt),
                                 $sampled(aw_cnt)));

  a_job_done: assert property (@(posedge clk) disable iff (!rst_n) job_end |-> done)
    else stop_on_error("Done was low after the job finished");

  a_job_error: assert property (@(posedge clk) disable iff (!rst_n)
    job_end |-> error == exp_error)
    else stop_on_error($sformatf("Error %s o_error expected %0b actual %0b", test_name,
                                 $sampled(exp_error), $sampled(error)));

  // ========================================
  // Stimulus helpers
  // ========================================
  task automatic poke_word(input sa_pkg::addr_t addr, input sa_pkg::word_t data);
    bd_we   = 1'b1;
    bd_addr = addr;
    bd_data = data;
    @(negedge clk);
    bd_we = 1'b0;
  endtask

  task automatic set_cfg(input int k, input int ba, input int bb, input int bc,
                         input int sa, input int sb, input int sc);
    cfg.k_len    = 5'(k);
    cfg.base_a   = ba;
    cfg.base_b   = bb;
    cfg.base_c   = bc;
    cfg.stride_a = sa;
    cfg.stride_b = sb;
    cfg.stride_c = sc;
  endtask

  // Random tiles into memory, and C computed from them
  task automatic fill_tiles();
    logic signed [7:0] a_el [4][16];
    logic signed [7:0] b_el [16][4];
    int                kl;
    int                acc;
    kl = int'(cfg.k_len);
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < kl; k++) begin
        a_el[i][k] = 8'($random(seed));
      end
    end
    for (int k = 0; k < kl; k++) begin
      for (int j = 0; j < 4; j++) begin
        b_el[k][j] = 8'($random(seed));
      end
    end
    for (int i = 0; i < 4; i++) begin
      for (int wd = 0; wd < kl / 4; wd++) begin
        poke_word(cfg.base_a + sa_pkg::addr_t'(i) * cfg.stride_a + 32'(4 * wd),
                  {a_el[i][4*wd+3], a_el[i][4*wd+2], a_el[i][4*wd+1], a_el[i][4*wd]});
      end
    end
    for (int k = 0; k < kl; k++) begin
      poke_word(cfg.base_b + sa_pkg::addr_t'(k) * cfg.stride_b,
                {b_el[k][3], b_el[k][2], b_el[k][1], b_el[k][0]});
    end
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        acc = 0;
        for (int k = 0; k < kl; k++) begin
          acc = acc + int'(a_el[i][k]) * int'(b_el[k][j]);
        end
        exp_c[i*4+j] = acc;
      end
    end
  endtask

  task automatic run_job(input string name, input logic err, input bit restart);
    test_name = name;
    exp_error = err;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (restart) begin
      repeat (3) @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    while (busy) begin
      @(negedge clk);
    end
    job_end = 1'b1;
    @(negedge clk);
    job_end = 1'b0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_on_error($sformatf("Timeout: the run did not finish within %0d ns", WATCHDOG_NS));
  end

  initial begin
    rst_n       = 1'b0;
    start       = 1'b0;
    cfg         = '0;
    bd_we       = 1'b0;
    bd_addr     = '0;
    bd_data     = '0;
    err_beat    = -1;
    exp_error   = 1'b0;
    job_end     = 1'b0;
    illegal_job = 1'b0;
    test_name   = "reset";
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    set_cfg(16, 'h000, 'h100, 'h200, 16, 4, 16);
    fill_tiles();
    run_job("full_range_k16", 1'b0, 1'b0);

    set_cfg(4, 'h300, 'h400, 'h500, 'h20, 'h0c, 'h40);
    fill_tiles();
    run_job("short_k4_gaps", 1'b0, 1'b0);

    set_cfg(6, 'h300, 'h400, 'h500, 'h20, 'h0c, 'h40);
    illegal_job = 1'b1;
    run_job("illegal_k6", 1'b1, 1'b0);
    repeat (4) @(negedge clk);
    illegal_job = 1'b0;

    set_cfg(8, 'h600, 'h700, 'h800, 8, 4, 16);
    fill_tiles();
    err_beat = rd_beats + 2;
    run_job("read_slverr", 1'b1, 1'b0);
    err_beat = -1;
    fill_tiles();
    run_job("after_error_k8", 1'b0, 1'b0);

    set_cfg(12, 'h900, 'ha00, 'hb00, 12, 4, 16);
    fill_tiles();
    run_job("start_while_busy", 1'b0, 1'b1);

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: tb_axi_mem.sv
// 4 KB word memory, single burst per direction; only address bits 11:2 are decoded
module tb_axi_mem (
  input  logic            M_AXI_ACLK,
  input  logic            M_AXI_ARESETN,
  input  sa_pkg::axi_ar_t i_ar,
  input  logic            i_arvalid,
  input  logic            i_rready,
  input  sa_pkg::axi_aw_t i_aw,
  input  logic            i_awvalid,
  input  sa_pkg::axi_w_t  i_w,
  input  logic            i_wvalid,
  input  logic            i_bready,
  input  logic            i_bd_we,
  input  sa_pkg::addr_t   i_bd_addr,
  input  sa_pkg::word_t   i_bd_data,
  input  int              i_err_beat,
  output logic            o_arready,
  output sa_pkg::axi_r_t  o_r,
  output logic            o_rvalid,
  output logic            o_awready,
  output logic            o_wready,
  output sa_pkg::axi_b_t  o_b,
  output logic            o_bvalid,
  output int              o_rd_beats
);
  timeunit 1ns;
  timeprecision 1ps;

  sa_pkg::word_t mem [1024];
  int            seed = 32'hd71;
  sa_pkg::addr_t rd_addr;
  sa_pkg::addr_t wr_addr;
  int            rd_left;
  logic          b_pend;
  logic          r_taken;
  logic          b_taken;

  // ========================================
  // Transfers seen at the rising edge
  // ========================================
  always @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN) begin
    if (!M_AXI_ARESETN) begin
      rd_left    <= 0;
      b_pend     <= 1'b0;
      r_taken    <= 1'b0;
      b_taken    <= 1'b0;
      o_rd_beats <= 0;
    end else begin
      r_taken <= o_rvalid && i_rready;
      b_taken <= o_bvalid && i_bready;
      if (i_bd_we) begin
        mem[i_bd_addr[11:2]] <= i_bd_data;
      end
      if (i_arvalid && o_arready) begin
        rd_addr <= i_ar.addr;
        rd_left <= int'(i_ar.len) + 1;
      end
      if (o_rvalid && i_rready) begin
        rd_addr    <= rd_addr + 32'd4;
        rd_left    <= rd_left - 1;
        o_rd_beats <= o_rd_beats + 1;
      end
      if (i_awvalid && o_awready) begin
        wr_addr <= i_aw.addr;
      end
      if (i_wvalid && o_wready) begin
        mem[wr_addr[11:2]] <= i_w.data;
        wr_addr            <= wr_addr + 32'd4;
        if (i_w.last) begin
          b_pend <= 1'b1;
        end
      end
      if (o_bvalid && i_bready) begin
        b_pend <= 1'b0;
      end
    end
  end

  // ========================================
  // Outputs change on the falling edge
  // ========================================
  always @(negedge M_AXI_ACLK or negedge M_AXI_ARESETN) begin
    if (!M_AXI_ARESETN) begin
      o_arready <= 1'b0;
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_rvalid  <= 1'b0;
      o_bvalid  <= 1'b0;
      o_r       <= '0;
      o_b       <= '0;
    end else begin
      // Ready about three cycles in four
      o_arready <= ($random(seed) & 3) != 0;
      o_awready <= ($random(seed) & 3) != 0;
      o_wready  <= ($random(seed) & 3) != 0;
      // A raised valid holds until the beat is taken
      if (!o_rvalid || r_taken) begin
        o_rvalid  <= (rd_left > 0) && (($random(seed) & 3) != 0);
        o_r.data  <= mem[rd_addr[11:2]];
        o_r.last  <= (rd_left == 1);
        o_r.resp  <= (o_rd_beats == i_err_beat) ? 2'b10 : sa_pkg::AXI_OKAY;
      end
      if (!o_bvalid || b_taken) begin
        o_bvalid <= b_pend && (($random(seed) & 3) != 0);
        o_b.resp <= sa_pkg::AXI_OKAY;
      end
    end
  end

endmodule

// File: sa_engine_top.sv
// Single 4x4 tile per start; i_cfg must be held stable while o_busy is high
module sa_engine_top (
  input  logic            M_AXI_ACLK,
  input  logic            M_AXI_ARESETN,
  input  logic            i_start,
  input  sa_pkg::sa_cfg_t i_cfg,
  input  logic            i_arready,
  input  sa_pkg::axi_r_t  i_r,
  input  logic            i_rvalid,
  input  logic            i_awready,
  input  logic            i_wready,
  input  sa_pkg::axi_b_t  i_b,
  input  logic            i_bvalid,
  output sa_pkg::axi_ar_t o_ar,
  output logic            o_arvalid,
  output logic            o_rready,
  output sa_pkg::axi_aw_t o_aw,
  output logic            o_awvalid,
  output sa_pkg::axi_w_t  o_w,
  output logic            o_wvalid,
  output logic            o_bready,
  output logic            o_busy,
  output logic            o_done,
  output logic            o_error
);

  // ========================================
  // Inter-block wires
  // ========================================
  logic            ld_start;
  logic            ld_done;
  logic            ld_err;
  logic            cmp_start;
  logic            cmp_done;
  logic            st_start;
  logic            st_done;
  logic            st_err;
  logic            a_we;
  logic            b_we;
  sa_pkg::kcnt_t   widx;
  sa_pkg::word_t   wdata;
  sa_pkg::c_tile_t c_tile;

  tile_controller u_controller (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .i_start       (i_start),
    .i_k_len       (i_cfg.k_len),
    .i_ld_done     (ld_done),
    .i_ld_err      (ld_err),
    .i_cmp_done    (cmp_done),
    .i_st_done     (st_done),
    .i_st_err      (st_err),
    .o_ld_start    (ld_start),
    .o_cmp_start   (cmp_start),
    .o_st_start    (st_start),
    .o_busy        (o_busy),
    .o_done        (o_done),
    .o_error       (o_error)
  );

  tile_loader u_loader (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .i_start       (ld_start),
    .i_cfg         (i_cfg),
    .i_arready     (i_arready),
    .i_r           (i_r),
    .i_rvalid      (i_rvalid),
    .o_ar          (o_ar),
    .o_arvalid     (o_arvalid),
    .o_rready      (o_rready),
    .o_a_we        (a_we),
    .o_b_we        (b_we),
    .o_widx        (widx),
    .o_wdata       (wdata),
    .o_done        (ld_done),
    .o_err         (ld_err)
  );

  tile_compute u_compute (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .i_a_we        (a_we),
    .i_b_we        (b_we),
    .i_widx        (widx),
    .i_wdata       (wdata),
    .i_k_len       (i_cfg.k_len),
    .i_start       (cmp_start),
    .o_c           (c_tile),
    .o_done        (cmp_done)
  );

  tile_store u_store (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .i_start       (st_start),
    .i_cfg         (i_cfg),
    .i_c           (c_tile),
    .i_awready     (i_awready),
    .i_wready      (i_wready),
    .i_b           (i_b),
    .i_bvalid      (i_bvalid),
    .o_aw          (o_aw),
    .o_awvalid     (o_awvalid),
    .o_w           (o_w),
    .o_wvalid      (o_wvalid),
    .o_bready      (o_bready),
    .o_done        (st_done),
    .o_err         (st_err)
  );

endmodule

// File: tile_store.sv
// One write burst in flight; i_c and i_cfg must stay stable until done
module tile_store (
  input  logic            M_AXI_ACLK,
  input  logic            M_AXI_ARESETN,
  input  logic            i_start,
  input  sa_pkg::sa_cfg_t i_cfg,
  input  sa_pkg::c_tile_t i_c,
  input  logic            i_awready,
  input  logic            i_wready,
  input  sa_pkg::axi_b_t  i_b,
  input  logic            i_bvalid,
  output sa_pkg::axi_aw_t o_aw,
  output logic            o_awvalid,
  output sa_pkg::axi_w_t  o_w,
  output logic            o_wvalid,
  output logic            o_bready,
  output logic            o_done,
  output logic            o_err
);

  sa_pkg::st_state_e state_q;
  logic [1:0]        row_q;
  logic [1:0]        beat_q;
  logic              err_q;
  sa_pkg::addr_t     addr_q;
  logic              b_fire;
  logic              bad_resp;

  assign b_fire   = o_bready && i_bvalid;
  assign bad_resp = b_fire && (i_b.resp != sa_pkg::AXI_OKAY);

  assign o_awvalid = (state_q == sa_pkg::ST_ADDR);
  assign o_wvalid  = (state_q == sa_pkg::ST_DATA);
  assign o_bready  = (state_q == sa_pkg::ST_RESP);

  // Every row is one four-beat burst
  assign o_aw.addr = addr_q;
  assign o_aw.len  = 8'(sa_pkg::TILE - 1);
  assign o_w.data  = i_c[{row_q, beat_q}];
  assign o_w.strb  = '1;
  assign o_w.last  = (beat_q == 2'd3);

  assign o_done = b_fire && (row_q == 2'd3);
  assign o_err  = err_q || bad_resp;

  // ========================================
  // Row bursts
  // ========================================
  always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN) begin
    if (!M_AXI_ARESETN) begin
      state_q <= sa_pkg::ST_IDLE;
      row_q   <= '0;
      beat_q  <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        sa_pkg::ST_IDLE: begin
          if (i_start) begin
            state_q <= sa_pkg::ST_ADDR;
            row_q   <= '0;
            err_q   <= 1'b0;
          end
        end
        sa_pkg::ST_ADDR: begin
          if (i_awready) begin
            state_q <= sa_pkg::ST_DATA;
            beat_q  <= '0;
          end
        end
        sa_pkg::ST_DATA: begin
          if (i_wready) begin
            beat_q <= beat_q + 2'd1;
            if (o_w.last) begin
              state_q <= sa_pkg::ST_RESP;
            end
          end
        end
        sa_pkg::ST_RESP: begin
          if (i_bvalid) begin
            if (bad_resp) begin
              err_q <= 1'b1;
            end
            row_q   <= row_q + 2'd1;
            state_q <= (row_q == 2'd3) ? sa_pkg::ST_IDLE : sa_pkg::ST_ADDR;
          end
        end
        default: state_q <= sa_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge M_AXI_ACLK) begin
    if ((state_q == sa_pkg::ST_IDLE) && i_start) begin
      addr_q <= i_cfg.base_c;
    end else if (b_fire) begin
      addr_q <= addr_q + i_cfg.stride_c;
    end
  end

  // W payload holds while the slave stalls
  a_w_stable: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    o_wvalid && !i_wready |=> o_wvalid && $stable(o_w));

endmodule

// File: tile_compute.sv
// Tiles must be fully written before start; i_k_len must stay stable until done
module tile_compute (
  input  logic            M_AXI_ACLK,
  input  logic            M_AXI_ARESETN,
  input  logic            i_a_we,
  input  logic            i_b_we,
  input  sa_pkg::kcnt_t   i_widx,
  input  sa_pkg::word_t   i_wdata,
  input  sa_pkg::kcnt_t   i_k_len,
  input  logic            i_start,
  output sa_pkg::c_tile_t o_c,
  output logic            o_done
);

  // A kept row-major with a row pitch of K
  sa_pkg::elem_t   a_mem [sa_pkg::TILE*sa_pkg::K_MAX];
  sa_pkg::elem_t   b_mem [sa_pkg::K_MAX][sa_pkg::TILE];
  sa_pkg::c_tile_t acc_q;
  sa_pkg::acc_t    prod [sa_pkg::TILE*sa_pkg::TILE];
  sa_pkg::kcnt_t   k_q;
  sa_pkg::kcnt_t   k_sel;
  logic            running_q;
  logic            done_q;

  // The start cycle already works on k = 0
  assign k_sel  = i_start ? '0 : k_q;
  assign o_c    = acc_q;
  assign o_done = done_q;

  // ========================================
  // Tile storage
  // ========================================
  always_ff @(posedge M_AXI_ACLK) begin
    for (int e = 0; e < sa_pkg::TILE; e++) begin
      if (i_a_we) begin
        a_mem[{i_widx[3:0], 2'b00} + 6'(e)] <= i_wdata[e*sa_pkg::ELEM_W +: sa_pkg::ELEM_W];
      end
      if (i_b_we) begin
        b_mem[i_widx[3:0]][e] <= i_wdata[e*sa_pkg::ELEM_W +: sa_pkg::ELEM_W];
      end
    end
  end

  // 16 signed products for the current k
  always_comb begin
    logic [5:0] a_idx;
    for (int i = 0; i < sa_pkg::TILE; i++) begin
      for (int j = 0; j < sa_pkg::TILE; j++) begin
        a_idx = 6'(i) * {1'b0, i_k_len} + {1'b0, k_sel};
        prod[i*sa_pkg::TILE+j] = sa_pkg::acc_t'(a_mem[a_idx]) *
                                 sa_pkg::acc_t'(b_mem[k_sel[3:0]][j]);
      end
    end
  end

  // ========================================
  // Accumulation
  // ========================================
  always_ff @(posedge M_AXI_ACLK) begin
    for (int n = 0; n < sa_pkg::TILE*sa_pkg::TILE; n++) begin
      if (i_start) begin
        acc_q[n] <= prod[n];
      end else if (running_q) begin
        acc_q[n] <= acc_q[n] + prod[n];
      end
    end
  end

  always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN) begin
    if (!M_AXI_ARESETN) begin
      running_q <= 1'b0;
      k_q       <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (i_start) begin
        running_q <= 1'b1;
        k_q       <= 5'd1;
      end else if (running_q) begin
        if (k_q == i_k_len - 5'd1) begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end else begin
          k_q <= k_q + 5'd1;
        end
      end
    end
  end

  // Loader writes must be over before the sums start
  a_no_write_busy: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    (i_start || running_q) |-> !(i_a_we || i_b_we));

endmodule

// File: tile_loader.sv
// One read burst in flight; RLAST closes each burst and i_cfg must stay stable for the job
module tile_loader (
  input  logic            M_AXI_ACLK,
  input  logic            M_AXI_ARESETN,
  input  logic            i_start,
  input  sa_pkg::sa_cfg_t i_cfg,
  input  logic            i_arready,
  input  sa_pkg::axi_r_t  i_r,
  input  logic            i_rvalid,
  output sa_pkg::axi_ar_t o_ar,
  output logic            o_arvalid,
  output logic            o_rready,
  output logic            o_a_we,
  output logic            o_b_we,
  output sa_pkg::kcnt_t   o_widx,
  output sa_pkg::word_t   o_wdata,
  output logic            o_done,
  output logic            o_err
);

  sa_pkg::ld_state_e        state_q;
  sa_pkg::kcnt_t            row_q;
  logic [1:0]               beat_q;
  logic                     is_b_q;
  logic                     err_q;
  sa_pkg::addr_t            addr_q;
  sa_pkg::kcnt_t            words_per_row;
  logic [sa_pkg::LEN_W-1:0] a_len;
  logic                     r_fire;
  logic                     bad_beat;
  logic                     row_end_a;
  logic                     row_end_b;

  assign words_per_row = {2'b00, i_cfg.k_len[4:2]};
  assign a_len         = 8'(words_per_row) - 8'd1;
  assign r_fire        = o_rready && i_rvalid;
  assign bad_beat      = r_fire && (i_r.resp != sa_pkg::AXI_OKAY);
  assign row_end_a     = (row_q == sa_pkg::kcnt_t'(sa_pkg::TILE - 1));
  assign row_end_b     = (row_q == i_cfg.k_len - 5'd1);

  assign o_arvalid = (state_q == sa_pkg::LD_ADDR);
  assign o_rready  = (state_q == sa_pkg::LD_DATA);
  assign o_ar.addr = addr_q;
  // B rows are single words
  assign o_ar.len  = is_b_q ? '0 : a_len;

  assign o_a_we  = r_fire && !is_b_q;
  assign o_b_we  = r_fire && is_b_q;
  assign o_wdata = i_r.data;
  assign o_widx  = is_b_q ? row_q : row_q * words_per_row + {3'b000, beat_q};
  assign o_done  = r_fire && i_r.last && is_b_q && row_end_b;
  assign o_err   = err_q || bad_beat;

  // ========================================
  // Burst sequencing
  // ========================================
  always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN) begin
    if (!M_AXI_ARESETN) begin
      state_q <= sa_pkg::LD_IDLE;
      row_q   <= '0;
      beat_q  <= '0;
      is_b_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        sa_pkg::LD_IDLE: begin
          if (i_start) begin
            state_q <= sa_pkg::LD_ADDR;
            row_q   <= '0;
            is_b_q  <= 1'b0;
            err_q   <= 1'b0;
          end
        end
        sa_pkg::LD_ADDR: begin
          if (i_arready) begin
            state_q <= sa_pkg::LD_DATA;
            beat_q  <= '0;
          end
        end
        sa_pkg::LD_DATA: begin
          if (i_rvalid) begin
            beat_q <= beat_q + 2'd1;
            if (bad_beat) begin
              err_q <= 1'b1;
            end
            if (i_r.last) begin
              if (!is_b_q && row_end_a) begin
                is_b_q  <= 1'b1;
                row_q   <= '0;
                state_q <= sa_pkg::LD_ADDR;
              end else if (is_b_q && row_end_b) begin
                state_q <= sa_pkg::LD_IDLE;
              end else begin
                row_q   <= row_q + 5'd1;
                state_q <= sa_pkg::LD_ADDR;
              end
            end
          end
        end
        default: state_q <= sa_pkg::LD_IDLE;
      endcase
    end
  end

  // Row address walks base plus stride, then jumps to the B base
  always_ff @(posedge M_AXI_ACLK) begin
    if ((state_q == sa_pkg::LD_IDLE) && i_start) begin
      addr_q <= i_cfg.base_a;
    end else if (r_fire && i_r.last) begin
      if (!is_b_q && row_end_a) begin
        addr_q <= i_cfg.base_b;
      end else if (is_b_q) begin
        addr_q <= addr_q + i_cfg.stride_b;
      end else begin
        addr_q <= addr_q + i_cfg.stride_a;
      end
    end
  end

  a_ar_stable: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    o_arvalid && !i_arready |=> o_arvalid && $stable(o_ar));

endmodule

// File: tile_controller.sv
// One job at a time; a start while busy is dropped, and i_k_len is only checked at start
module tile_controller (
  input  logic          M_AXI_ACLK,
  input  logic          M_AXI_ARESETN,
  input  logic          i_start,
  input  sa_pkg::kcnt_t i_k_len,
  input  logic          i_ld_done,
  input  logic          i_ld_err,
  input  logic          i_cmp_done,
  input  logic          i_st_done,
  input  logic          i_st_err,
  output logic          o_ld_start,
  output logic          o_cmp_start,
  output logic          o_st_start,
  output logic          o_busy,
  output logic          o_done,
  output logic          o_error
);

  sa_pkg::ctrl_state_e state_q;
  logic                accept;
  logic                k_ok;
  logic                done_q;
  logic                error_q;

  assign accept = (state_q == sa_pkg::CTRL_IDLE) && i_start;

  // Legal K is nonzero, a multiple of 4 and at most K_MAX
  assign k_ok = (i_k_len != '0) && (i_k_len[1:0] == 2'b00) &&
                (i_k_len <= sa_pkg::kcnt_t'(sa_pkg::K_MAX));

  assign o_busy  = (state_q != sa_pkg::CTRL_IDLE);
  assign o_done  = done_q;
  assign o_error = error_q;

  // ========================================
  // Job sequencing
  // ========================================
  always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN) begin
    if (!M_AXI_ARESETN) begin
      state_q     <= sa_pkg::CTRL_IDLE;
      done_q      <= 1'b0;
      error_q     <= 1'b0;
      o_ld_start  <= 1'b0;
      o_cmp_start <= 1'b0;
      o_st_start  <= 1'b0;
    end else begin
      o_ld_start  <= accept && k_ok;
      o_cmp_start <= (state_q == sa_pkg::CTRL_LOAD) && i_ld_done;
      o_st_start  <= (state_q == sa_pkg::CTRL_COMPUTE) && i_cmp_done;
      case (state_q)
        sa_pkg::CTRL_IDLE: begin
          if (i_start) begin
            // Bad K finishes at once with the error flag
            done_q  <= !k_ok;
            error_q <= !k_ok;
            if (k_ok) begin
              state_q <= sa_pkg::CTRL_LOAD;
            end
          end
        end
        sa_pkg::CTRL_LOAD: begin
          if (i_ld_done) begin
            state_q <= sa_pkg::CTRL_COMPUTE;
            if (i_ld_err) begin
              error_q <= 1'b1;
            end
          end
        end
        sa_pkg::CTRL_COMPUTE: begin
          if (i_cmp_done) begin
            state_q <= sa_pkg::CTRL_STORE;
          end
        end
        sa_pkg::CTRL_STORE: begin
          if (i_st_done) begin
            state_q <= sa_pkg::CTRL_IDLE;
            done_q  <= 1'b1;
            if (i_st_err) begin
              error_q <= 1'b1;
            end
          end
        end
        default: state_q <= sa_pkg::CTRL_IDLE;
      endcase
    end
  end

  a_start_onehot: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    $onehot0({o_ld_start, o_cmp_start, o_st_start}));

  a_busy_done_excl: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    !(o_busy && o_done));

endmodule

// File: sa_pkg.sv
// Sizes are tied to four signed bytes per 32-bit word; K must be a multiple of 4 from 4 to 16
package sa_pkg;

  // ========================================
  // Sizes
  // ========================================
  localparam int TILE   = 4;
  localparam int K_MAX  = 16;
  localparam int ELEM_W = 8;
  localparam int ACC_W  = 32;
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int LEN_W  = 8;

  // ========================================
  // Vector types
  // ========================================
  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic [DATA_W-1:0]        word_t;
  typedef logic [ADDR_W-1:0]        addr_t;
  // Holds K up to 16 and any k index below it
  typedef logic [4:0]               kcnt_t;
  typedef logic [1:0]               resp_t;

  localparam resp_t AXI_OKAY = 2'b00;

  // ========================================
  // State machines
  // ========================================
  typedef enum logic [1:0] {CTRL_IDLE, CTRL_LOAD, CTRL_COMPUTE, CTRL_STORE} ctrl_state_e;
  typedef enum logic [1:0] {LD_IDLE, LD_ADDR, LD_DATA} ld_state_e;
  typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA, ST_RESP} st_state_e;

  // Job configuration, strides in bytes
  typedef struct packed {
    kcnt_t k_len;
    addr_t base_a;
    addr_t base_b;
    addr_t base_c;
    addr_t stride_a;
    addr_t stride_b;
    addr_t stride_c;
  } sa_cfg_t;

  // Reduced AXI4 channel payloads
  typedef struct packed {
    addr_t            addr;
    logic [LEN_W-1:0] len;
  } axi_ar_t;

  typedef struct packed {
    word_t data;
    resp_t resp;
    logic  last;
  } axi_r_t;

  typedef struct packed {
    addr_t            addr;
    logic [LEN_W-1:0] len;
  } axi_aw_t;

  typedef struct packed {
    word_t               data;
    logic [DATA_W/8-1:0] strb;
    logic                last;
  } axi_w_t;

  typedef struct packed {
    resp_t resp;
  } axi_b_t;

  // Row i, column j at index i*TILE+j
  typedef acc_t [TILE*TILE-1:0] c_tile_t;

endpackage
